/* sys_mapper.f */
hw/mapper_pkg.sv
hw/mmr_bus_if.sv
hw/mmr_arbiter.sv
hw/mapper_regs.sv
hw/region_decode.sv
hw/cpu_bus_ctrl.sv
hw/sys_mapper.sv
verif/sys_mapper_sva.sv
verif/tb_sys_mapper.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the sys_mapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sys_mapper -f sys_mapper.f -o sim_sys_mapper
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_sys_mapper)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
    exit 0
fi
exit 1

/* verif/tb_sys_mapper.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sys_mapper
    import mapper_pkg::*;
();

    // tests take about 1000 cycles, limit at twice that
    localparam int MAX_CYCLES = 2000;

    // register window, a23 set so no region base can match
    localparam cpu_addr_t REG_WIN = 23'h40_0000;

    logic clk;
    logic rst;
    cpu_addr_t cpu_addr;
    logic [15:0] cpu_dout;
    logic cpu_asn;
    logic [1:0] cpu_dswn;
    fc_t cpu_fc;
    logic ext_ackn;
    logic vint;
    reg_addr_t mcu_addr;
    byte_t mcu_dout;
    logic mcu_wr;
    logic snd_rd;
    logic [3:0] st_addr;
    logic cpu_dtackn;
    logic cpu_vpan;
    logic [2:0] cpu_ipln;
    logic mcu_intn;
    byte_t snd_dout;
    logic snd_obf;
    region_mask_t active;
    byte_t st_dout;

    // model of the register file and the lockout
    byte_t model_regs [NUM_REGS];
    logic model_locked;
    logic decode_on;
    int n_checks;
    int n_errors;
    int n_cycles = 0;

    sys_mapper UUT (
        .clk        (clk),
        .rst        (rst),
        .cpu_addr   (cpu_addr),
        .cpu_dout   (cpu_dout),
        .cpu_asn    (cpu_asn),
        .cpu_dswn   (cpu_dswn),
        .cpu_fc     (cpu_fc),
        .ext_ackn   (ext_ackn),
        .vint       (vint),
        .mcu_addr   (mcu_addr),
        .mcu_dout   (mcu_dout),
        .mcu_wr     (mcu_wr),
        .snd_rd     (snd_rd),
        .st_addr    (st_addr),
        .cpu_dtackn (cpu_dtackn),
        .cpu_vpan   (cpu_vpan),
        .cpu_ipln   (cpu_ipln),
        .mcu_intn   (mcu_intn),
        .snd_dout   (snd_dout),
        .snd_obf    (snd_obf),
        .active     (active),
        .st_dout    (st_dout)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        n_cycles <= n_cycles + 1;
        if (n_cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    // expected one-hot select and wait code from the model bytes
    // walks from the top region down so the lowest index is left
    function automatic region_mask_t expected_region(input cpu_addr_t addr, input fc_t fc,
                                                     output wait_code_t wc);
        region_mask_t mask;
        byte_t cfg;
        byte_t base;
        int nbits;
        mask = '0;
        wc = '0;
        if (fc != 3'd7) begin
            for (int i = NUM_REGIONS - 1; i >= 0; i--) begin
                cfg = model_regs[16 + 2*i];
                base = model_regs[17 + 2*i];
                case (cfg[1:0])
                    2'd0: nbits = 8;
                    2'd1: nbits = 7;
                    2'd2: nbits = 5;
                    default: nbits = 3;
                endcase
                if ((32'(addr) >> (23 - nbits)) == (32'(base) >> (8 - nbits))) begin
                    mask = region_mask_t'(1) << i;
                    wc = cfg[3:2];
                end
            end
        end
        return mask;
    endfunction

    // status index 0-7 is base i, 8-15 is config of region index-8
    function automatic byte_t expected_status(input logic [3:0] a);
        int idx;
        if (a < 4'd8) begin
            idx = 17 + 2*int'(a);
        end else begin
            idx = 16 + 2*(int'(a) - 8);
        end
        return model_regs[idx];
    endfunction

    task automatic check_mask(input region_mask_t got, input region_mask_t exp,
                              input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED at %0t ns: %s, active %b, expected %b",
                     $time, what, got, exp);
        end
    endtask

    task automatic check_byte(input byte_t got, input byte_t exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                     $time, what, got, exp);
        end
    endtask

    task automatic check_cycles(input int got, input int exp, input string what);
        n_checks++;
        if (got != exp) begin
            n_errors++;
            $display("CHECK FAILED at %0t ns: %s, %0d cycles, expected %0d",
                     $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED at %0t ns: %s, got %b, expected %b",
                     $time, what, got, exp);
        end
    endtask

    // one bus cycle, counts edges from the first strobe sample to dtack
    // ext_ackn pulled low on count ext_delay, 0 never
    task automatic cpu_access(input cpu_addr_t addr, input fc_t fc, input logic [1:0] dswn,
                              input byte_t data, input int ext_delay, output int cycles);
        cycles = 0;
        @(posedge clk);
        cpu_addr <= addr;
        cpu_fc <= fc;
        cpu_dswn <= dswn;
        cpu_dout <= {8'h00, data};
        cpu_asn <= 1'b0;
        // strobe sampled here
        @(posedge clk);
        while (cycles < 16) begin
            @(posedge clk);
            cycles++;
            if (cycles == ext_delay) begin
                ext_ackn <= 1'b0;
            end
            @(negedge clk);
            if (!cpu_dtackn) begin
                break;
            end
        end
        if (cpu_dtackn) begin
            n_errors++;
            $display("no dtack within 16 cycles of the address strobe at %0t ns", $time);
        end
        // end of cycle
        @(posedge clk);
        cpu_asn <= 1'b1;
        cpu_dswn <= 2'b11;
        ext_ackn <= 1'b1;
        @(posedge clk);
    endtask

    // low byte write outside every region
    task automatic cpu_write(input reg_addr_t r, input byte_t data);
        int cycles;
        cpu_access(REG_WIN | cpu_addr_t'(r), 3'd5, 2'b10, data, 0, cycles);
        check_cycles(cycles, 1, "register write dtack");
        if (!model_locked) begin
            model_regs[r] = data;
        end
    endtask

    task automatic mcu_write(input reg_addr_t r, input byte_t data);
        @(posedge clk);
        mcu_wr <= 1'b1;
        mcu_addr <= r;
        mcu_dout <= data;
        @(posedge clk);
        mcu_wr <= 1'b0;
        model_regs[r] = data;
        model_locked = 1'b1;
    endtask

    // st_dout is one edge behind st_addr
    task automatic status_read(input logic [3:0] a, output byte_t value);
        @(posedge clk);
        st_addr <= a;
        @(posedge clk);
        @(negedge clk);
        value = st_dout;
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (n_errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, n_errors - errors_before);
        end
    endtask

    // decode compare while the address sweep runs
    always @(negedge clk) begin : decode_check
        region_mask_t exp_mask;
        wait_code_t exp_wc;
        if (decode_on) begin
            exp_mask = expected_region(cpu_addr, cpu_fc, exp_wc);
            check_mask(active, exp_mask, "region decode");
        end
    end

    initial begin
        int e0;
        int cycles;
        int delay;
        byte_t value;
        byte_t v;
        byte_t page;
        cpu_addr_t a;
        wait_code_t wc;
        region_mask_t exp_mask;

        void'($urandom(14));
        clk = 1'b0;
        rst = 1'b1;
        cpu_addr = '0;
        cpu_dout = '0;
        cpu_asn = 1'b1;
        cpu_dswn = 2'b11;
        cpu_fc = 3'd5;
        ext_ackn = 1'b1;
        vint = 1'b0;
        mcu_addr = '0;
        mcu_dout = '0;
        mcu_wr = 1'b0;
        snd_rd = 1'b0;
        st_addr = '0;
        decode_on = 1'b0;
        model_locked = 1'b0;
        n_checks = 0;
        n_errors = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // cpu programs the region map
        e0 = n_errors;
        for (int r = 16; r < 32; r++) begin
            v = byte_t'($urandom);
            // bases keep a23 clear
            if (r % 2 == 1) begin
                v[7] = 1'b0;
            end
            cpu_write(reg_addr_t'(r), v);
        end
        for (int i = 0; i < 16; i++) begin
            status_read(4'(i), value);
            check_byte(value, expected_status(4'(i)), "status readback");
        end
        end_test("cpu register programming", e0);

        // random decode over overlapping bases
        e0 = n_errors;
        for (int round = 0; round < 4; round++) begin
            for (int i = 0; i < NUM_REGIONS; i++) begin
                cpu_write(reg_addr_t'(16 + 2*i), byte_t'($urandom));
                cpu_write(reg_addr_t'(17 + 2*i), 8'h20 | byte_t'($urandom % 16));
            end
            decode_on = 1'b1;
            for (int n = 0; n < 50; n++) begin
                a = cpu_addr_t'($urandom);
                // mostly inside the band the bases live in
                if (n % 4 != 0) begin
                    a[23:16] = 8'h20 | byte_t'($urandom % 32);
                end
                @(posedge clk);
                cpu_addr <= a;
                cpu_fc <= fc_t'($urandom);
            end
            @(posedge clk);
            decode_on = 1'b0;
        end
        end_test("region decode", e0);

        // region i: 64 kB at 0x40+i, wait code i mod 4
        e0 = n_errors;
        for (int i = 0; i < NUM_REGIONS; i++) begin
            cpu_write(reg_addr_t'(16 + 2*i), byte_t'((i % 4) << 2));
            cpu_write(reg_addr_t'(17 + 2*i), 8'h40 + 8'(i));
        end
        for (int i = 0; i < 5; i++) begin
            // last access hits nothing
            page = (i == 4) ? 8'h60 : 8'h40 + 8'(i);
            a = {page, 15'($urandom)};
            delay = 1 + int'($urandom % 6);
            exp_mask = expected_region(a, 3'd6, wc);
            cpu_access(a, 3'd6, 2'b01, 8'h00, (wc == 2'd3) ? delay : 0, cycles);
            @(negedge clk);
            check_mask(active, exp_mask, "wait test region");
            if (wc == 2'd3) begin
                check_cycles(cycles, delay + 1, "dtack after external ack");
            end else begin
                check_cycles(cycles, int'(wc) + 1, "dtack wait states");
            end
        end
        end_test("wait states", e0);

        // sound mailbox
        e0 = n_errors;
        v = byte_t'($urandom);
        cpu_write(reg_addr_t'(SND_LATCH_REG), v);
        @(negedge clk);
        check_flag(snd_obf, 1'b1, "mailbox full after write");
        check_byte(snd_dout, v, "mailbox data");
        @(posedge clk);
        snd_rd <= 1'b1;
        @(posedge clk);
        snd_rd <= 1'b0;
        @(negedge clk);
        check_flag(snd_obf, 1'b0, "mailbox empty after read");
        // read lands on the write edge, two edges after the strobe
        v = ~v;
        fork
            cpu_write(reg_addr_t'(SND_LATCH_REG), v);
            begin
                @(posedge clk);
                @(posedge clk);
                snd_rd <= 1'b1;
                @(posedge clk);
                snd_rd <= 1'b0;
            end
        join
        @(negedge clk);
        check_flag(snd_obf, 1'b0, "read wins over write");
        check_byte(snd_dout, v, "mailbox data after second write");
        end_test("mailbox", e0);

        // vblank interrupt and autovector ack
        e0 = n_errors;
        @(negedge clk);
        check_flag(cpu_ipln[2], 1'b1, "no request before vblank");
        @(posedge clk);
        vint <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_flag(cpu_ipln[2], 1'b1, "request one edge after vblank");
        @(posedge clk);
        @(negedge clk);
        check_flag(cpu_ipln[2], 1'b0, "request two edges after vblank");
        check_flag(&cpu_ipln[1:0], 1'b1, "only level 4 requested");
        check_flag(mcu_intn, 1'b0, "mcu interrupt");
        @(posedge clk);
        vint <= 1'b0;
        fork
            cpu_access(23'h7F_FFFC, fc_t'(IACK_FC), 2'b11, 8'h00, 0, cycles);
            begin
                @(posedge clk);
                @(negedge clk);
                check_flag(cpu_vpan, 1'b0, "vpa during acknowledge");
            end
        join
        @(negedge clk);
        check_flag(cpu_vpan, 1'b1, "vpa after acknowledge");
        check_flag(cpu_ipln[2], 1'b1, "request cleared");
        check_flag(mcu_intn, 1'b1, "mcu interrupt cleared");
        end_test("interrupt", e0);

        // mcu takes the register file
        e0 = n_errors;
        check_flag(UUT.mmr_bus.cpu_locked, model_locked, "lockout clear before mcu write");
        v = byte_t'($urandom) & 8'h7F;
        mcu_write(reg_addr_t'(17), v);
        status_read(4'd0, value);
        check_byte(value, v, "mcu write to base 0");
        check_flag(UUT.mmr_bus.cpu_locked, model_locked, "lockout set by mcu write");
        cpu_write(reg_addr_t'(17), ~v);
        status_read(4'd0, value);
        check_byte(value, expected_status(4'd0), "cpu locked out of base 0");
        cpu_write(reg_addr_t'(20), ~model_regs[20]);
        status_read(4'd10, value);
        check_byte(value, expected_status(4'd10), "cpu locked out of config 2");
        end_test("mcu takeover", e0);

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/sys_mapper_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module sys_mapper_sva (
    input logic clk,
    input logic rst,
    input logic cpu_asn,
    input logic cpu_dtackn,
    input logic cpu_vpan,
    input logic cpu_wr_req,
    input logic mcu_intn
);

    // set once a write request was given in the current bus cycle
    logic req_seen;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_seen <= 1'b0;
        end else if (cpu_asn) begin
            req_seen <= 1'b0;
        end else if (cpu_wr_req) begin
            req_seen <= 1'b1;
        end
    end

    // dtack only inside a bus cycle, never on its first edge
    dtack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        !cpu_dtackn |-> (!cpu_asn && $past(!cpu_asn)))
        else $error("dtack low outside a running bus cycle");

    // autovector ack drops the pending request by the next edge
    vpa_on_iack: assert property (@(posedge clk) disable iff (rst)
        !cpu_vpan |=> mcu_intn)
        else $error("interrupt request still pending after acknowledge");

    // write request is a single pulse per bus cycle
    wr_req_pulse: assert property (@(posedge clk) disable iff (rst)
        cpu_wr_req |-> !req_seen)
        else $error("cpu write request repeated within one bus cycle");

endmodule

bind cpu_bus_ctrl sys_mapper_sva u_sva (
    .clk        (clk),
    .rst        (rst),
    .cpu_asn    (cpu_asn),
    .cpu_dtackn (cpu_dtackn),
    .cpu_vpan   (cpu_vpan),
    .cpu_wr_req (cpu_wr_req),
    .mcu_intn   (mcu_intn)
);

`default_nettype wire

/* hw/sys_mapper.sv */
`timescale 1ns/1ps
`default_nettype none

module sys_mapper
    import mapper_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  cpu_addr_t    cpu_addr,
    input  logic [15:0]  cpu_dout,
    input  logic         cpu_asn,
    input  logic [1:0]   cpu_dswn,
    input  fc_t          cpu_fc,
    input  logic         ext_ackn,
    input  logic         vint,
    input  reg_addr_t    mcu_addr,
    input  byte_t        mcu_dout,
    input  logic         mcu_wr,
    input  logic         snd_rd,
    input  logic [3:0]   st_addr,
    output logic         cpu_dtackn,
    output logic         cpu_vpan,
    output logic [2:0]   cpu_ipln,
    output logic         mcu_intn,
    output byte_t        snd_dout,
    output logic         snd_obf,
    output region_mask_t active,
    output byte_t        st_dout
);

    region_cfg_t region_cfg;
    wait_code_t wait_code;
    logic cpu_wr_req;

    // arbitrated register write
    mmr_bus_if mmr_bus();

    // cpu register index from a5..a1, data on the low byte lane
    mmr_arbiter u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .cpu_wr_req   (cpu_wr_req),
        .cpu_addr_reg (cpu_addr[5:1]),
        .cpu_wdata    (cpu_dout[7:0]),
        .mcu_wr       (mcu_wr),
        .mcu_addr     (mcu_addr),
        .mcu_wdata    (mcu_dout),
        .bus          (mmr_bus)
    );

    mapper_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .bus        (mmr_bus),
        .snd_rd     (snd_rd),
        .snd_dout   (snd_dout),
        .snd_obf    (snd_obf),
        .st_addr    (st_addr),
        .st_dout    (st_dout),
        .region_cfg (region_cfg)
    );

    region_decode u_decode (
        .cpu_addr   (cpu_addr),
        .cpu_fc     (cpu_fc),
        .region_cfg (region_cfg),
        .active     (active),
        .wait_code  (wait_code)
    );

    cpu_bus_ctrl u_bus_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cpu_asn    (cpu_asn),
        .cpu_dswn   (cpu_dswn),
        .cpu_fc     (cpu_fc),
        .ext_ackn   (ext_ackn),
        .vint       (vint),
        .active     (active),
        .wait_code  (wait_code),
        .cpu_wr_req (cpu_wr_req),
        .cpu_dtackn (cpu_dtackn),
        .cpu_vpan   (cpu_vpan),
        .cpu_ipln   (cpu_ipln),
        .mcu_intn   (mcu_intn)
    );

endmodule

`default_nettype wire

/* hw/cpu_bus_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_ctrl
    import mapper_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         cpu_asn,
    input  logic [1:0]   cpu_dswn,
    input  fc_t          cpu_fc,
    input  logic         ext_ackn,
    input  logic         vint,
    input  region_mask_t active,
    input  wait_code_t   wait_code,
    output logic         cpu_wr_req,
    output logic         cpu_dtackn,
    output logic         cpu_vpan,
    output logic [2:0]   cpu_ipln,
    output logic         mcu_intn
);

    ack_state_t ack_state;
    wait_code_t wait_lat;
    wait_code_t wait_cnt;
    logic vint_s1;
    logic vint_s2;
    logic irq;
    logic iack;
    logic wr_cond;
    logic wr_seen;

    // dtack wait states
    // wait code captured once, at the start of the access
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_state <= ACK_IDLE;
            wait_lat <= '0;
            wait_cnt <= '0;
        end else begin
            case (ack_state)
                ACK_IDLE: begin
                    if (!cpu_asn) begin
                        ack_state <= ACK_WAIT;
                        wait_lat <= wait_code;
                        wait_cnt <= '0;
                    end
                end
                ACK_WAIT: begin
                    if (cpu_asn) begin
                        // strobe dropped early
                        ack_state <= ACK_IDLE;
                    end else if (wait_lat == 2'd3) begin
                        if (!ext_ackn) begin
                            ack_state <= ACK_DONE;
                        end
                    end else if (wait_cnt == wait_lat) begin
                        ack_state <= ACK_DONE;
                    end else begin
                        wait_cnt <= wait_cnt + 2'd1;
                    end
                end
                default: begin
                    // hold ack until the cpu lets go of the strobe
                    if (cpu_asn) begin
                        ack_state <= ACK_IDLE;
                    end
                end
            endcase
        end
    end

    // released as soon as the strobe goes high
    assign cpu_dtackn = (ack_state != ACK_DONE) || cpu_asn;

    // vblank edge detect on two samples
    assign iack = (cpu_fc == fc_t'(IACK_FC)) && !cpu_asn;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vint_s1 <= 1'b0;
            vint_s2 <= 1'b0;
            irq <= 1'b0;
        end else begin
            vint_s1 <= vint;
            vint_s2 <= vint_s1;
            // ack has priority over a new edge
            if (iack) begin
                irq <= 1'b0;
            end else if (vint_s1 && !vint_s2) begin
                irq <= 1'b1;
            end
        end
    end

    // autovector on ack, level 4 request
    assign cpu_vpan = !iack;
    assign cpu_ipln = {!irq, 2'b11};
    assign mcu_intn = !irq;

    // low byte write outside all regions goes to the register file
    assign wr_cond = !cpu_asn && !cpu_dswn[0] && (active == '0);

    // one pulse per access
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_seen <= 1'b0;
            cpu_wr_req <= 1'b0;
        end else begin
            wr_seen <= wr_cond;
            cpu_wr_req <= wr_cond && !wr_seen;
        end
    end

endmodule

`default_nettype wire

/* hw/region_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module region_decode
    import mapper_pkg::*;
(
    input  cpu_addr_t    cpu_addr,
    input  fc_t          cpu_fc,
    input  region_cfg_t  region_cfg,
    output region_mask_t active,
    output wait_code_t   wait_code
);

    region_mask_t hit;
    region_mask_t lowest;

    // compare the top address bits against the base byte
    // larger regions compare fewer bits
    function automatic logic base_match(cpu_addr_t addr, byte_t cfg, byte_t base);
        size_code_t size;
        size = cfg[1:0];
        case (size)
            2'd0:    base_match = addr[23:16] == base;
            2'd1:    base_match = addr[23:17] == base[7:1];
            2'd2:    base_match = addr[23:19] == base[7:3];
            default: base_match = addr[23:21] == base[7:5];
        endcase
    endfunction

    // raw hits, several regions may overlap
    always_comb begin
        for (int i = 0; i < NUM_REGIONS; i++) begin
            hit[i] = base_match(cpu_addr, region_cfg[2*i], region_cfg[2*i+1]);
        end
    end

    // isolate lowest set bit, lowest index wins
    assign lowest = hit & (~hit + region_mask_t'(1));

    // irq ack cycles never hit a region
    assign active = (cpu_fc == fc_t'(IACK_FC)) ? '0 : lowest;

    // wait code from bits 3:2 of the winning config byte
    always_comb begin
        wait_code = '0;
        for (int i = 0; i < NUM_REGIONS; i++) begin
            if (active[i]) begin
                wait_code = region_cfg[2*i][3:2];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/mapper_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module mapper_regs
    import mapper_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    mmr_bus_if.regs     bus,
    input  logic        snd_rd,
    output byte_t       snd_dout,
    output logic        snd_obf,
    input  logic [3:0]  st_addr,
    output byte_t       st_dout,
    output region_cfg_t region_cfg
);

    byte_t mmr [NUM_REGS];
    reg_addr_t st_sel;

    // register file, all bytes zero out of reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                mmr[i] <= '0;
            end
        end else if (bus.wr) begin
            mmr[bus.addr] <= bus.wdata;
        end
    end

    // mailbox full flag
    // sound side read beats a write in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd_obf <= 1'b0;
        end else if (snd_rd) begin
            snd_obf <= 1'b0;
        end else if (bus.wr && bus.addr == reg_addr_t'(SND_LATCH_REG)) begin
            snd_obf <= 1'b1;
        end
    end

    assign snd_dout = mmr[SND_LATCH_REG];

    // status index: 0-7 -> base bytes, 8-15 -> config bytes
    assign st_sel = reg_addr_t'(CFG_BASE_REG + {st_addr[2:0], ~st_addr[3]});

    // one cycle behind st_addr
    always_ff @(posedge clk) begin
        st_dout <= mmr[st_sel];
    end

    // upper half of the file is the region map
    always_comb begin
        for (int i = 0; i < 2*NUM_REGIONS; i++) begin
            region_cfg[i] = mmr[CFG_BASE_REG + i];
        end
    end

endmodule

`default_nettype wire

/* hw/mmr_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mmr_arbiter
    import mapper_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cpu_wr_req,
    input  reg_addr_t cpu_addr_reg,
    input  byte_t     cpu_wdata,
    input  logic      mcu_wr,
    input  reg_addr_t mcu_addr,
    input  byte_t     mcu_wdata,
    mmr_bus_if.arb    bus
);

    logic locked;

    // first mcu write takes the register file for good
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            locked <= 1'b0;
        end else if (mcu_wr) begin
            locked <= 1'b1;
        end
    end

    // mcu wins, cpu only while not locked out
    // a cpu request in the same cycle as an mcu write is lost
    always_comb begin
        if (mcu_wr) begin
            bus.wr = 1'b1;
            bus.addr = mcu_addr;
            bus.wdata = mcu_wdata;
        end else begin
            bus.wr = cpu_wr_req && !locked;
            bus.addr = cpu_addr_reg;
            bus.wdata = cpu_wdata;
        end
    end

    // visible to the checkers only
    assign bus.cpu_locked = locked;

endmodule

`default_nettype wire

/* hw/mmr_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mmr_bus_if
    import mapper_pkg::*;
();

    // single-cycle write strobe into the register file
    logic wr;
    reg_addr_t addr;
    byte_t wdata;

    // sticky flag, cpu has lost register access
    logic cpu_locked;

    // arbiter side
    modport arb (
        output wr,
        output addr,
        output wdata,
        output cpu_locked
    );

    // register file side
    modport regs (
        input wr,
        input addr,
        input wdata
    );

endinterface

`default_nettype wire

/* hw/mapper_pkg.sv */
`default_nettype none

package mapper_pkg;

    // mapper geometry
    localparam int NUM_REGIONS = 8;
    localparam int NUM_REGS = 32;

    // one-byte mailbox towards the sound cpu
    localparam int SND_LATCH_REG = 3;

    // region i: config byte at 16+2i, base byte at 17+2i
    localparam int CFG_BASE_REG = 16;

    // all function code bits set on interrupt acknowledge
    localparam int IACK_FC = 7;

    // 68000 word address, a0 is not on the bus
    typedef logic [23:1] cpu_addr_t;
    typedef logic [7:0] byte_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [NUM_REGIONS-1:0] region_mask_t;

    // 0: 64 kB, 1: 128 kB, 2: 512 kB, 3: 2 MB
    typedef logic [1:0] size_code_t;

    // 0..2: ack after code+1 cycles, 3: external ack
    typedef logic [1:0] wait_code_t;
    typedef logic [2:0] fc_t;

    // config and base bytes of every region, from register 16 up
    typedef byte_t [2*NUM_REGIONS-1:0] region_cfg_t;

    // dtack state machine
    typedef enum logic [1:0] {
        ACK_IDLE,
        ACK_WAIT,
        ACK_DONE
    } ack_state_t;

endpackage

`default_nettype wire
